// ==== hw/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// first fetch address out of reset
`define FETCH_PC_RESET 32'h1c00_0000

// andi r0, r0, 0
// fills an unused or squashed slot
`define FETCH_INST_NOP 32'h0340_0000

// entries in the instruction queue
`define FETCH_QUEUE_DEPTH 8

// opcode byte inst[31:24] of the serializing classes
`define FETCH_OP_IBAR 8'h38
`define FETCH_OP_CSR 8'h04
`define FETCH_OP_TLB 8'h06

`endif

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

    // one fetch packet as held in the instruction queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [1:0]  excp;
    } fetch_packet_t;

    // predecode result for a packet
    typedef enum logic [1:0] {
        NONE = 2'd0,
        IBAR = 2'd1,
        CSR  = 2'd2,
        TLB  = 2'd3
    } serial_kind_t;

    // align stage serialization FSM
    typedef enum logic [2:0] {
        IDLE            = 3'b000,
        WAIT_EX_IBAR    = 3'b001,
        WAIT_EX_CSR     = 3'b010,
        WAIT_CACHE_IDLE = 3'b011,
        WAIT_CSR_DONE   = 3'b100,
        WAIT_TLB_DONE   = 3'b101,
        WAIT_EX_TLB     = 3'b111
    } serial_state_t;

endpackage

// ==== hw/fetch_pc_gen.sv ====
`include "fetch_defs.svh"

module fetch_pc_gen (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic        serial_redirect,
    input  logic [31:0] serial_pc,
    input  logic        fetch_hold,
    input  logic        nearly_full,
    output logic        icache_req,
    output logic [31:0] icache_pc,
    output logic        req_live,
    output logic [31:0] icache_pc_q
);

    logic [31:0] fetch_pc;
    logic [31:0] seq_pc;
    logic        req_en;

    // next 8-byte boundary, drops bit 2 of an unaligned target
    assign seq_pc = {fetch_pc[31:3] + 29'd1, 3'b000};

    // no request in a redirect cycle, fetch_pc is about to change
    assign icache_req = req_en && !fetch_hold && !nearly_full && !flush && !serial_redirect;
    assign icache_pc  = fetch_pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetch_pc <= `FETCH_PC_RESET;
            req_en   <= 1'b0;
            req_live <= 1'b0;
        end else begin
            req_en   <= 1'b1;
            req_live <= icache_req;
            if (flush) begin
                fetch_pc <= flush_pc;
            end else if (serial_redirect) begin
                fetch_pc <= serial_pc;
            end else if (icache_req) begin
                fetch_pc <= seq_pc;
            end
        end
    end

    // pc of the request being answered this cycle
    always_ff @(posedge clk) begin
        if (icache_req) begin
            icache_pc_q <= fetch_pc;
        end
    end

endmodule

// ==== hw/fetch_align_stage.sv ====
`include "fetch_defs.svh"

module fetch_align_stage (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     icache_rvalid,
    input  logic                     req_live,
    input  logic [31:0]              icache_pc_q,
    input  logic [31:0]              icache_inst0,
    input  logic [31:0]              icache_inst1,
    input  logic [1:0]               icache_excp,
    input  logic                     ex_ibar,
    input  logic                     ex_csr,
    input  logic                     ex_tlb,
    input  logic                     cache_idle,
    input  logic                     csr_done,
    input  logic                     tlb_done,
    output logic                     pkt_valid,
    output fetch_pkg::fetch_packet_t pkt,
    output logic                     fetch_hold,
    output logic                     serial_redirect,
    output logic [31:0]              serial_pc
);

    fetch_pkg::serial_state_t state_q;
    fetch_pkg::serial_state_t state_d;
    fetch_pkg::serial_kind_t  kind0;
    fetch_pkg::serial_kind_t  kind1;
    fetch_pkg::serial_kind_t  pkt_kind;
    logic                     accept;
    logic [31:0]              slot0;
    logic [31:0]              slot1;
    logic [31:0]              slot1_final;
    logic [31:0]              resume_pc;

    function automatic fetch_pkg::serial_kind_t predecode(input logic [31:0] inst);
        fetch_pkg::serial_kind_t kind;
        case (inst[31:24])
            `FETCH_OP_IBAR: kind = fetch_pkg::IBAR;
            `FETCH_OP_CSR:  kind = fetch_pkg::CSR;
            `FETCH_OP_TLB:  kind = fetch_pkg::TLB;
            default:        kind = fetch_pkg::NONE;
        endcase
        return kind;
    endfunction

    // stale answers carry req_live low; a held stage takes nothing
    assign accept = icache_rvalid && req_live && (state_q == fetch_pkg::IDLE) && !flush;

    // upper word goes first when the pc points at it
    always_comb begin
        if (icache_pc_q[2]) begin
            slot0 = icache_inst1;
            slot1 = `FETCH_INST_NOP;
        end else begin
            slot0 = icache_inst0;
            slot1 = icache_inst1;
        end
    end

    assign kind0 = predecode(slot0);
    assign kind1 = predecode(slot1);

    // serializing slot 0 squashes slot 1 and resumes right after it
    always_comb begin
        if (kind0 != fetch_pkg::NONE) begin
            pkt_kind    = kind0;
            slot1_final = `FETCH_INST_NOP;
            resume_pc   = icache_pc_q + 32'd4;
        end else begin
            pkt_kind    = kind1;
            slot1_final = slot1;
            resume_pc   = icache_pc_q + 32'd8;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pkt.pc    <= icache_pc_q;
            pkt.inst0 <= slot0;
            pkt.inst1 <= slot1_final;
            pkt.excp  <= icache_excp;
        end
    end

    // resume point of the pending serializing instruction
    always_ff @(posedge clk) begin
        if (accept && (pkt_kind != fetch_pkg::NONE)) begin
            serial_pc <= resume_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state_q <= fetch_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d         = state_q;
        serial_redirect = 1'b0;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (accept) begin
                    case (pkt_kind)
                        fetch_pkg::IBAR: state_d = fetch_pkg::WAIT_EX_IBAR;
                        fetch_pkg::CSR:  state_d = fetch_pkg::WAIT_EX_CSR;
                        fetch_pkg::TLB:  state_d = fetch_pkg::WAIT_EX_TLB;
                        default:         state_d = fetch_pkg::IDLE;
                    endcase
                end
            end
            fetch_pkg::WAIT_EX_IBAR: begin
                if (ex_ibar) state_d = fetch_pkg::WAIT_CACHE_IDLE;
            end
            fetch_pkg::WAIT_EX_CSR: begin
                if (ex_csr) state_d = fetch_pkg::WAIT_CSR_DONE;
            end
            fetch_pkg::WAIT_EX_TLB: begin
                if (ex_tlb) state_d = fetch_pkg::WAIT_TLB_DONE;
            end
            // side effect finished, send fetch to the resume pc
            fetch_pkg::WAIT_CACHE_IDLE: begin
                if (cache_idle) begin
                    state_d         = fetch_pkg::IDLE;
                    serial_redirect = !flush;
                end
            end
            fetch_pkg::WAIT_CSR_DONE: begin
                if (csr_done) begin
                    state_d         = fetch_pkg::IDLE;
                    serial_redirect = !flush;
                end
            end
            fetch_pkg::WAIT_TLB_DONE: begin
                if (tlb_done) begin
                    state_d         = fetch_pkg::IDLE;
                    serial_redirect = !flush;
                end
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
    end

    assign fetch_hold = (state_q != fetch_pkg::IDLE);

endmodule

// ==== hw/fetch_inst_queue.sv ====
`include "fetch_defs.svh"

module fetch_inst_queue #(
    parameter type payload_t = fetch_pkg::fetch_packet_t,
    parameter int  DEPTH     = `FETCH_QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop_ready,
    output logic     pop_valid,
    output payload_t pop_data,
    output logic     nearly_full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          do_push;
    logic          do_pop;

    // wrap for any depth, not only powers of two
    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        if (ptr == PW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = (count == CW'(DEPTH));
    assign pop_valid   = (count != '0);
    assign pop_data    = mem[rd_ptr];
    assign do_push     = push && !full;
    assign do_pop      = pop_valid && pop_ready;
    // two slots left for the request in flight and the stage register
    assign nearly_full = (count >= CW'(DEPTH - 2));

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
module fetch_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic        icache_rvalid,
    input  logic [31:0] icache_inst0,
    input  logic [31:0] icache_inst1,
    input  logic [1:0]  icache_excp,
    input  logic        ex_ibar,
    input  logic        ex_csr,
    input  logic        ex_tlb,
    input  logic        cache_idle,
    input  logic        csr_done,
    input  logic        tlb_done,
    input  logic        inst_ready,
    output logic        icache_req,
    output logic [31:0] icache_pc,
    output logic        inst_valid,
    output logic [31:0] inst_pc,
    output logic [31:0] inst0,
    output logic [31:0] inst1,
    output logic [1:0]  inst_excp
);

    logic                     req_live;
    logic [31:0]              icache_pc_q;
    logic                     fetch_hold;
    logic                     serial_redirect;
    logic [31:0]              serial_pc;
    logic                     nearly_full;
    logic                     pkt_valid;
    fetch_pkg::fetch_packet_t pkt;
    fetch_pkg::fetch_packet_t q_data;

    fetch_pc_gen u_pc_gen (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .flush_pc        (flush_pc),
        .serial_redirect (serial_redirect),
        .serial_pc       (serial_pc),
        .fetch_hold      (fetch_hold),
        .nearly_full     (nearly_full),
        .icache_req      (icache_req),
        .icache_pc       (icache_pc),
        .req_live        (req_live),
        .icache_pc_q     (icache_pc_q)
    );

    fetch_align_stage u_align (
        .clk             (clk),
        .rstn            (rstn),
        .flush           (flush),
        .icache_rvalid   (icache_rvalid),
        .req_live        (req_live),
        .icache_pc_q     (icache_pc_q),
        .icache_inst0    (icache_inst0),
        .icache_inst1    (icache_inst1),
        .icache_excp     (icache_excp),
        .ex_ibar         (ex_ibar),
        .ex_csr          (ex_csr),
        .ex_tlb          (ex_tlb),
        .cache_idle      (cache_idle),
        .csr_done        (csr_done),
        .tlb_done        (tlb_done),
        .pkt_valid       (pkt_valid),
        .pkt             (pkt),
        .fetch_hold      (fetch_hold),
        .serial_redirect (serial_redirect),
        .serial_pc       (serial_pc)
    );

    fetch_inst_queue #(
        .payload_t (fetch_pkg::fetch_packet_t)
    ) u_queue (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .push        (pkt_valid),
        .push_data   (pkt),
        .pop_ready   (inst_ready),
        .pop_valid   (inst_valid),
        .pop_data    (q_data),
        .nearly_full (nearly_full)
    );

    // decode side takes the packet as loose fields
    assign inst_pc   = q_data.pc;
    assign inst0     = q_data.inst0;
    assign inst1     = q_data.inst1;
    assign inst_excp = q_data.excp;

endmodule

// ==== testbench/fetch_chk.sv ====
`include "fetch_defs.svh"

module fetch_chk (
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic pkt_valid,
    input logic inst_valid,
    input logic inst_ready,
    input logic fetch_hold,
    input logic serial_redirect
);

    timeunit 1ns;
    timeprecision 100ps;

    // queue occupancy as seen from its ports
    logic [4:0] occ;

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            occ <= '0;
        end else begin
            case ({pkt_valid, inst_valid && inst_ready})
                2'b10:   occ <= occ + 5'd1;
                2'b01:   occ <= occ - 5'd1;
                default: occ <= occ;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        (pkt_valid && !flush) |-> (occ < `FETCH_QUEUE_DEPTH))
        else $error("packet pushed into a full queue");

    a_redirect_pulse: assert property (@(posedge clk) disable iff (!rstn)
        serial_redirect |=> !serial_redirect)
        else $error("serial_redirect longer than one cycle");

    // only the serializing packet itself may follow the start of a hold
    a_no_pkt_hold: assert property (@(posedge clk) disable iff (!rstn)
        (fetch_hold && $past(fetch_hold)) |-> !pkt_valid)
        else $error("packet registered during serialization hold");

    a_valid_reset: assert property (@(posedge clk) !rstn |=> !inst_valid)
        else $error("inst_valid high after reset");

endmodule

bind fetch_top fetch_chk chk0 (
    .clk             (clk),
    .rstn            (rstn),
    .flush           (flush),
    .pkt_valid       (pkt_valid),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .fetch_hold      (fetch_hold),
    .serial_redirect (serial_redirect)
);

// ==== testbench/fetch_tb.sv ====
`include "fetch_defs.svh"

module fetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h863b_de4e;
    localparam int NROWS = 10;

    // one scenario step
    typedef struct {
        logic                    do_flush;
        logic [31:0]             flush_pc;
        int                      cycles;
        logic                    rand_ready;
        logic [31:0]             ser_pc;
        fetch_pkg::serial_kind_t kind;
        int                      ex_dly;
        int                      done_dly;
    } row_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        flush;
    logic [31:0] flush_pc;
    logic        icache_rvalid;
    logic [31:0] icache_inst0;
    logic [31:0] icache_inst1;
    logic [1:0]  icache_excp;
    logic        ex_ibar;
    logic        ex_csr;
    logic        ex_tlb;
    logic        cache_idle;
    logic        csr_done;
    logic        tlb_done;
    logic        inst_ready;
    logic        icache_req;
    logic [31:0] icache_pc;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [1:0]  inst_excp;

    row_t        rows [NROWS];
    int          r;
    int          limit;
    int          cycles = 0;
    int          val_errs = 0;
    int          other_errs = 0;
    logic [31:0] rng = SEED;
    logic [31:0] exp_pc;
    logic [31:0] pend_pc;
    logic        pend_req;
    int          since_flush;
    int          ser_timer;
    int          pops;
    bit          waiting_first;
    bit          gate;
    bit          ser_active;
    bit          ser_seen;
    bit          ser_done;
    bit          resumed;

    fetch_top dut0 (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not end within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] opcode_of(input fetch_pkg::serial_kind_t kind);
        case (kind)
            fetch_pkg::IBAR: return `FETCH_OP_IBAR;
            fetch_pkg::CSR:  return `FETCH_OP_CSR;
            default:         return `FETCH_OP_TLB;
        endcase
    endfunction

    // cache contents, a pc hash unless the row marks this word as serializing
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] x;
        if (rows[r].kind != fetch_pkg::NONE && addr == rows[r].ser_pc) begin
            return {opcode_of(rows[r].kind), addr[23:0]};
        end
        x = lcg_next(addr ^ SEED);
        x = lcg_next(x ^ (x >> 13));
        if (x[31:24] == `FETCH_OP_IBAR || x[31:24] == `FETCH_OP_CSR ||
            x[31:24] == `FETCH_OP_TLB) begin
            x[31] = ~x[31];
        end
        return x;
    endfunction

    // one faulting page
    function automatic logic [1:0] excp_at(input logic [31:0] pc);
        return (pc[31:12] == 20'h1c010) ? 2'b01 : 2'b00;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            val_errs++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // expected packet from the pc sequence and the row's serializing word
    task automatic check_packet();
        logic [31:0] base;
        logic [31:0] e0;
        logic [31:0] e1;
        logic [31:0] nxt;
        bit          ser;
        base = {exp_pc[31:3], 3'b000};
        e0   = exp_pc[2] ? word_at(base + 32'd4) : word_at(base);
        e1   = exp_pc[2] ? `FETCH_INST_NOP : word_at(base + 32'd4);
        nxt  = base + 32'd8;
        ser  = 1'b0;
        if (rows[r].kind != fetch_pkg::NONE) begin
            if (exp_pc == rows[r].ser_pc) begin
                e1  = `FETCH_INST_NOP;
                nxt = exp_pc + 32'd4;
                ser = 1'b1;
            end else if (!exp_pc[2] && exp_pc + 32'd4 == rows[r].ser_pc) begin
                nxt = exp_pc + 32'd8;
                ser = 1'b1;
            end
        end
        assert (!gate) else begin
            other_errs++;
            $display("packet at pc %h reached decode before serialization completed", inst_pc);
        end
        check_val("inst_pc", inst_pc, exp_pc);
        check_val("inst0", inst0, e0);
        check_val("inst1", inst1, e1);
        check_val("inst_excp", {30'd0, inst_excp}, {30'd0, excp_at(exp_pc)});
        pops++;
        if (ser_done) resumed = 1'b1;
        if (ser) begin
            gate       = 1'b1;
            ser_active = 1'b1;
            ser_timer  = 0;
            ser_seen   = 1'b1;
        end
        exp_pc = nxt;
    endtask

    // one falling edge: cache answer, row control, execute reports, then sample
    task automatic run_cycle(input bit first);
        icache_rvalid = pend_req;
        icache_inst0  = word_at({pend_pc[31:3], 3'b000});
        icache_inst1  = word_at({pend_pc[31:3], 3'b100});
        icache_excp   = pend_req ? excp_at(pend_pc) : 2'b00;
        flush         = first && rows[r].do_flush;
        if (flush) begin
            flush_pc      = rows[r].flush_pc;
            exp_pc        = rows[r].flush_pc;
            since_flush   = 0;
            waiting_first = 1'b1;
        end else begin
            since_flush++;
        end
        if (rows[r].rand_ready) begin
            rng        = lcg_next(rng);
            inst_ready = rng[16];
        end else begin
            inst_ready = 1'b1;
        end
        {ex_ibar, ex_csr, ex_tlb, cache_idle, csr_done, tlb_done} = 6'b0;
        if (ser_active) begin
            ser_timer++;
            if (ser_timer == rows[r].ex_dly) begin
                ex_ibar = (rows[r].kind == fetch_pkg::IBAR);
                ex_csr  = (rows[r].kind == fetch_pkg::CSR);
                ex_tlb  = (rows[r].kind == fetch_pkg::TLB);
            end
            if (ser_timer == rows[r].ex_dly + rows[r].done_dly) begin
                cache_idle = (rows[r].kind == fetch_pkg::IBAR);
                csr_done   = (rows[r].kind == fetch_pkg::CSR);
                tlb_done   = (rows[r].kind == fetch_pkg::TLB);
            end
            if (ser_timer > rows[r].ex_dly + rows[r].done_dly) begin
                gate       = 1'b0;
                ser_active = 1'b0;
                ser_done   = 1'b1;
            end
        end
        #1;
        pend_req = icache_req;
        pend_pc  = icache_pc;
        if (waiting_first && since_flush > 0 && inst_valid) begin
            waiting_first = 1'b0;
            check_val("icache_req to inst_valid cycles", since_flush - 1, 32'd3);
        end
        if (inst_valid && inst_ready && !flush) check_packet();
    endtask

    initial begin
        rows[0] = '{1'b0, 32'h0,         60,  1'b0, 32'h0,         fetch_pkg::NONE, 0, 0};
        rows[1] = '{1'b1, 32'h1c00_2004, 50,  1'b0, 32'h0,         fetch_pkg::NONE, 0, 0};
        rows[2] = '{1'b1, 32'h1c00_4000, 150, 1'b1, 32'h0,         fetch_pkg::NONE, 0, 0};
        rows[3] = '{1'b1, 32'h1c00_6000, 70,  1'b0, 32'h1c00_6010, fetch_pkg::IBAR, 3, 4};
        rows[4] = '{1'b1, 32'h1c00_7000, 70,  1'b0, 32'h1c00_7014, fetch_pkg::IBAR, 2, 6};
        rows[5] = '{1'b1, 32'h1c00_8000, 70,  1'b0, 32'h1c00_8008, fetch_pkg::CSR,  1, 3};
        rows[6] = '{1'b1, 32'h1c00_9000, 70,  1'b0, 32'h1c00_900c, fetch_pkg::CSR,  4, 2};
        rows[7] = '{1'b1, 32'h1c00_a000, 120, 1'b1, 32'h1c00_a018, fetch_pkg::TLB,  2, 5};
        rows[8] = '{1'b1, 32'h1c00_b000, 70,  1'b0, 32'h1c00_b01c, fetch_pkg::TLB,  5, 1};
        rows[9] = '{1'b1, 32'h1c01_0fe0, 50,  1'b0, 32'h0,         fetch_pkg::NONE, 0, 0};
        limit = 200;
        foreach (rows[i]) limit += rows[i].cycles;
        r = 0;
        {rstn, flush, flush_pc, icache_rvalid, icache_inst0, icache_inst1} = '0;
        {icache_excp, ex_ibar, ex_csr, ex_tlb, cache_idle, csr_done, tlb_done} = '0;
        inst_ready = 1'b1;
        pend_req   = 1'b0;
        pend_pc    = '0;
        exp_pc     = `FETCH_PC_RESET;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        for (r = 0; r < NROWS; r++) begin
            {pops, gate, ser_active, ser_seen, ser_done, resumed} = '0;
            for (int c = 0; c < rows[r].cycles; c++) begin
                @(negedge clk);
                run_cycle(c == 0);
            end
            assert (pops >= 4) else begin
                other_errs++;
                $display("row %0d: only %0d packets reached decode", r, pops);
            end
            if (rows[r].kind != fetch_pkg::NONE) begin
                assert (ser_seen && resumed) else begin
                    other_errs++;
                    $display("row %0d: fetch did not resume after the serializing word", r);
                end
            end
        end
        r = NROWS - 1;
        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/fetch_align_stage.sv
hw/fetch_inst_queue.sv
hw/fetch_top.sv
testbench/fetch_chk.sv
testbench/fetch_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the fetch testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module fetch_tb -Mdir obj_dir -f all.f
	./obj_dir/Vfetch_tb > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
